// File: hw/soc_settings.svh
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// bytes of on-chip RAM, higher addresses alias onto it
`define SOC_RAM_DEPTH 256

// timer counter and compare width, split into two byte registers
`define SOC_TIMER_WIDTH 16

// galois feedback mask of the 16-bit PRNG
`define SOC_LFSR_TAPS 16'hB400

`endif

// File: hw/soc_bus_pkg.sv
package soc_bus_pkg;

    // one byte on the data bus
    typedef logic [7:0] wb_data_t;

    // address split into a 256-byte page and an offset within it
    typedef struct packed {
        logic [23:0] page;
        logic [7:0]  offset;
    } wb_addr_paged_t;

    // raw word for the RAM, paged view for decoder and peripherals
    typedef union packed {
        logic [31:0]    raw;
        wb_addr_paged_t paged;
    } wb_addr_u;

    typedef enum logic [1:0] {
        SEL_RAM,
        SEL_TIMER,
        SEL_PRNG,
        SEL_LEDS
    } slave_sel_e;

    // peripheral pages, everything else is RAM
    localparam logic [23:0] PAGE_TIMER = 24'hFFFFFD;
    localparam logic [23:0] PAGE_PRNG  = 24'hFFFFFE;
    localparam logic [23:0] PAGE_LEDS  = 24'hFFFFFF;

endpackage

// File: hw/soc_periph_pkg.sv
package soc_periph_pkg;

    // timer register map
    typedef enum logic [7:0] {
        TIMER_CMP_LO = 8'h00,
        TIMER_CMP_HI = 8'h01,
        TIMER_CTRL   = 8'h02,
        TIMER_STATUS = 8'h03
    } timer_reg_e;

    // control bits
    localparam int unsigned TIMER_CTRL_EN     = 0;
    localparam int unsigned TIMER_CTRL_IRQ_EN = 1;

    // status bits, write 1 to clear
    localparam int unsigned TIMER_STAT_PEND = 0;

    // prng register map
    typedef enum logic [7:0] {
        PRNG_SEED_LO = 8'h00,
        PRNG_SEED_HI = 8'h01,
        PRNG_OUT     = 8'h02
    } prng_reg_e;

endpackage

// File: hw/wb8_if.sv
`timescale 1ns/1ps

interface wb8_if import soc_bus_pkg::*; ();

    logic     stb;
    logic     we;
    wb_addr_u adr;
    wb_data_t dat_w;
    wb_data_t dat_r;
    logic     ack;

    modport master (
        output stb,
        output we,
        output adr,
        output dat_w,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  stb,
        input  we,
        input  adr,
        input  dat_w,
        output dat_r,
        output ack
    );

endinterface

// File: hw/wb8_decoder.sv
`timescale 1ns/1ps

module wb8_decoder import soc_bus_pkg::*; (
    wb8_if.slave  host_bus,
    wb8_if.master ram_bus,
    wb8_if.master timer_bus,
    wb8_if.master prng_bus,
    wb8_if.master leds_bus
);

    slave_sel_e sel;

    // page decode, unmapped pages fall through to RAM
    always_comb begin
        case (host_bus.adr.paged.page)
            PAGE_TIMER: sel = SEL_TIMER;
            PAGE_PRNG:  sel = SEL_PRNG;
            PAGE_LEDS:  sel = SEL_LEDS;
            default:    sel = SEL_RAM;
        endcase
    end

    // shared request fields go to every slave
    assign ram_bus.we     = host_bus.we;
    assign ram_bus.adr    = host_bus.adr;
    assign ram_bus.dat_w  = host_bus.dat_w;

    assign timer_bus.we    = host_bus.we;
    assign timer_bus.adr   = host_bus.adr;
    assign timer_bus.dat_w = host_bus.dat_w;

    assign prng_bus.we    = host_bus.we;
    assign prng_bus.adr   = host_bus.adr;
    assign prng_bus.dat_w = host_bus.dat_w;

    assign leds_bus.we    = host_bus.we;
    assign leds_bus.adr   = host_bus.adr;
    assign leds_bus.dat_w = host_bus.dat_w;

    // only the selected slave sees the strobe
    assign ram_bus.stb   = host_bus.stb && (sel == SEL_RAM);
    assign timer_bus.stb = host_bus.stb && (sel == SEL_TIMER);
    assign prng_bus.stb  = host_bus.stb && (sel == SEL_PRNG);
    assign leds_bus.stb  = host_bus.stb && (sel == SEL_LEDS);

    // return path
    always_comb begin
        case (sel)
            SEL_TIMER: begin
                host_bus.dat_r = timer_bus.dat_r;
                host_bus.ack   = timer_bus.ack;
            end
            SEL_PRNG: begin
                host_bus.dat_r = prng_bus.dat_r;
                host_bus.ack   = prng_bus.ack;
            end
            SEL_LEDS: begin
                host_bus.dat_r = leds_bus.dat_r;
                host_bus.ack   = leds_bus.ack;
            end
            default: begin
                host_bus.dat_r = ram_bus.dat_r;
                host_bus.ack   = ram_bus.ack;
            end
        endcase
    end

endmodule

// File: hw/ram_wb8.sv
`timescale 1ns/1ps

`include "soc_settings.svh"

module ram_wb8 import soc_bus_pkg::*; (
    input logic  clk,
    input logic  arst_n_i,
    wb8_if.slave bus
);

    localparam int unsigned ADDR_W = $clog2(`SOC_RAM_DEPTH);

    wb_data_t          mem [`SOC_RAM_DEPTH];
    logic [ADDR_W-1:0] idx;
    logic              access;

    // low address bits only, so the RAM repeats across the map
    assign idx    = bus.adr.raw[ADDR_W-1:0];
    assign access = bus.stb && !bus.ack;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            if (bus.we) begin
                mem[idx] <= bus.dat_w;
            end
            bus.dat_r <= mem[idx];
        end
    end

endmodule

// File: hw/timer_wb8.sv
`timescale 1ns/1ps

`include "soc_settings.svh"

module timer_wb8 import soc_bus_pkg::*, soc_periph_pkg::*; (
    input  logic clk,
    input  logic arst_n_i,
    wb8_if.slave bus,
    output logic irq_o
);

    logic [`SOC_TIMER_WIDTH-1:0] count;
    logic [`SOC_TIMER_WIDTH-1:0] compare;
    logic [1:0]                  ctrl;
    logic                        pending;
    logic                        access;
    logic                        wr;
    logic                        match;
    timer_reg_e                  reg_sel;
    wb_data_t                    rd_data;

    assign access  = bus.stb && !bus.ack;
    assign wr      = access && bus.we;
    assign reg_sel = timer_reg_e'(bus.adr.paged.offset);
    assign match   = ctrl[TIMER_CTRL_EN] && (count == compare);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus.ack <= 1'b0;
            compare <= '0;
            ctrl    <= '0;
        end else begin
            bus.ack <= access;
            if (wr) begin
                case (reg_sel)
                    TIMER_CMP_LO: compare[7:0] <= bus.dat_w;
                    TIMER_CMP_HI: compare[`SOC_TIMER_WIDTH-1:8] <= bus.dat_w;
                    TIMER_CTRL: begin
                        ctrl[TIMER_CTRL_EN]     <= bus.dat_w[TIMER_CTRL_EN];
                        ctrl[TIMER_CTRL_IRQ_EN] <= bus.dat_w[TIMER_CTRL_IRQ_EN];
                    end
                    default: ;
                endcase
            end
        end
    end

    // count up to compare, then wrap and flag
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count   <= '0;
            pending <= 1'b0;
        end else begin
            if (match) begin
                count <= '0;
            end else if (ctrl[TIMER_CTRL_EN]) begin
                count <= count + 1'b1;
            end
            // a new match wins over a clear in the same cycle
            if (match) begin
                pending <= 1'b1;
            end else if (wr && reg_sel == TIMER_STATUS && bus.dat_w[TIMER_STAT_PEND]) begin
                pending <= 1'b0;
            end
        end
    end

    always_comb begin
        rd_data = '0;
        case (reg_sel)
            TIMER_CMP_LO: rd_data = compare[7:0];
            TIMER_CMP_HI: rd_data = compare[`SOC_TIMER_WIDTH-1:8];
            TIMER_CTRL: begin
                rd_data[TIMER_CTRL_EN]     = ctrl[TIMER_CTRL_EN];
                rd_data[TIMER_CTRL_IRQ_EN] = ctrl[TIMER_CTRL_IRQ_EN];
            end
            TIMER_STATUS: rd_data[TIMER_STAT_PEND] = pending;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (access) begin
            bus.dat_r <= rd_data;
        end
    end

    assign irq_o = pending && ctrl[TIMER_CTRL_IRQ_EN];

endmodule

// File: hw/prng_wb8.sv
`timescale 1ns/1ps

`include "soc_settings.svh"

module prng_wb8 import soc_bus_pkg::*, soc_periph_pkg::*; (
    input logic  clk,
    input logic  arst_n_i,
    wb8_if.slave bus
);

    logic [15:0] state;
    logic [15:0] state_step;
    logic [15:0] state_seed;
    logic        access;
    prng_reg_e   reg_sel;

    assign access  = bus.stb && !bus.ack;
    assign reg_sel = prng_reg_e'(bus.adr.paged.offset);

    // galois step, taps folded in when a one falls out
    assign state_step = {1'b0, state[15:1]} ^ (state[0] ? `SOC_LFSR_TAPS : 16'h0000);

    always_comb begin
        state_seed = state;
        if (reg_sel == PRNG_SEED_LO) begin
            state_seed[7:0] = bus.dat_w;
        end else begin
            state_seed[15:8] = bus.dat_w;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus.ack <= 1'b0;
            state   <= 16'h0001;
        end else begin
            bus.ack <= access;
            if (access && bus.we && reg_sel != PRNG_OUT) begin
                // all-zero would lock the LFSR
                state <= (state_seed == 16'h0000) ? 16'h0001 : state_seed;
            end else if (access && !bus.we && reg_sel == PRNG_OUT) begin
                state <= state_step;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (reg_sel)
                PRNG_SEED_LO: bus.dat_r <= state[7:0];
                PRNG_SEED_HI: bus.dat_r <= state[15:8];
                PRNG_OUT:     bus.dat_r <= state[7:0];
                default:      bus.dat_r <= '0;
            endcase
        end
    end

endmodule

// File: hw/leds_wb8.sv
`timescale 1ns/1ps

module leds_wb8 import soc_bus_pkg::*; (
    input  logic     clk,
    input  logic     arst_n_i,
    wb8_if.slave     bus,
    output wb_data_t leds_o
);

    wb_data_t leds;
    logic     access;

    assign access = bus.stb && !bus.ack;

    // offset is ignored, whole page maps to one register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus.ack <= 1'b0;
            leds    <= '0;
        end else begin
            bus.ack <= access;
            if (access && bus.we) begin
                leds <= bus.dat_w;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            bus.dat_r <= leds;
        end
    end

    assign leds_o = leds;

endmodule

// File: hw/wb8_soc_top.sv
`timescale 1ns/1ps

module wb8_soc_top import soc_bus_pkg::*; (
    input  logic        clk,
    input  logic        arst_n_i,
    input  logic        bus_stb_i,
    input  logic        bus_we_i,
    input  logic [31:0] bus_adr_i,
    input  wb_data_t    bus_dat_i,
    output wb_data_t    bus_dat_o,
    output logic        bus_ack_o,
    output wb_data_t    leds_o,
    output logic        timer_irq_o
);

    wb8_if host_bus ();
    wb8_if ram_bus ();
    wb8_if timer_bus ();
    wb8_if prng_bus ();
    wb8_if leds_bus ();

    // external host onto the decoder link
    assign host_bus.stb   = bus_stb_i;
    assign host_bus.we    = bus_we_i;
    assign host_bus.adr   = wb_addr_u'(bus_adr_i);
    assign host_bus.dat_w = bus_dat_i;
    assign bus_dat_o      = host_bus.dat_r;
    assign bus_ack_o      = host_bus.ack;

    wb8_decoder u_decoder (
        .host_bus  (host_bus),
        .ram_bus   (ram_bus),
        .timer_bus (timer_bus),
        .prng_bus  (prng_bus),
        .leds_bus  (leds_bus)
    );

    ram_wb8 u_ram (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .bus      (ram_bus)
    );

    timer_wb8 u_timer (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .bus      (timer_bus),
        .irq_o    (timer_irq_o)
    );

    prng_wb8 u_prng (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .bus      (prng_bus)
    );

    leds_wb8 u_leds (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .bus      (leds_bus),
        .leds_o   (leds_o)
    );

endmodule

// File: test/wb8_soc_tb.sv
`timescale 1ns/1ps

`include "soc_settings.svh"

module wb8_soc_tb import soc_bus_pkg::*, soc_periph_pkg::*; ();

    localparam int unsigned TIMEOUT_CYCLES = 5000;
    localparam int unsigned ACK_WAIT_MAX   = 8;
    localparam int unsigned RAM_ACCESSES   = 24;
    localparam int unsigned PRNG_READS     = 10;
    localparam int unsigned POLL_MAX       = 64;

    logic        clk;
    logic        arst_n_i;
    logic        bus_stb_i;
    logic        bus_we_i;
    logic [31:0] bus_adr_i;
    wb_data_t    bus_dat_i;
    wb_data_t    bus_dat_o;
    logic        bus_ack_o;
    wb_data_t    leds_o;
    logic        timer_irq_o;

    int unsigned cycle_count = 0;
    int unsigned value_errors;
    int unsigned ack_errors;

    wb_data_t    ram_model [`SOC_RAM_DEPTH];
    logic [15:0] lfsr_model;

    wb8_soc_top u_dut (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .bus_stb_i   (bus_stb_i),
        .bus_we_i    (bus_we_i),
        .bus_adr_i   (bus_adr_i),
        .bus_dat_i   (bus_dat_i),
        .bus_dat_o   (bus_dat_o),
        .bus_ack_o   (bus_ack_o),
        .leds_o      (leds_o),
        .timer_irq_o (timer_irq_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic check_byte(input wb_data_t got, input wb_data_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("error at %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // ack is due at the first falling edge after the strobe
    task automatic wait_ack(input logic [31:0] adr);
        int unsigned waited;
        waited = 0;
        @(negedge clk);
        while (bus_ack_o !== 1'b1 && waited < ACK_WAIT_MAX) begin
            @(negedge clk);
            waited++;
        end
        if (waited != 0) begin
            ack_errors++;
            if (bus_ack_o === 1'b1) begin
                $display("acknowledge came %0d cycles late for address %08h at %0t ns",
                         waited, adr, $time);
            end else begin
                $display("acknowledge missing for address %08h at %0t ns", adr, $time);
            end
        end
    endtask

    task automatic bus_write(input logic [31:0] adr, input wb_data_t data);
        @(negedge clk);
        bus_stb_i = 1'b1;
        bus_we_i  = 1'b1;
        bus_adr_i = adr;
        bus_dat_i = data;
        wait_ack(adr);
        bus_stb_i = 1'b0;
        bus_we_i  = 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] adr, output wb_data_t data);
        @(negedge clk);
        bus_stb_i = 1'b1;
        bus_we_i  = 1'b0;
        bus_adr_i = adr;
        wait_ack(adr);
        data      = bus_dat_o;
        bus_stb_i = 1'b0;
    endtask

    // one galois step of the reference LFSR
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ `SOC_LFSR_TAPS;
        end
        return n;
    endfunction

    function automatic logic [15:0] seed_load(input logic [15:0] s, input wb_data_t b,
                                              input bit hi);
        logic [15:0] n;
        n = hi ? {b, s[7:0]} : {s[15:8], b};
        return (n == 16'h0000) ? 16'h0001 : n;
    endfunction

    // any address outside the three peripheral pages
    function automatic logic [31:0] ram_address();
        logic [31:0] a;
        a = $urandom;
        if (a[31:8] >= PAGE_TIMER) begin
            a[31] = 1'b0;
        end
        return a;
    endfunction

    task automatic test_reset();
        wb_data_t got;
        check_bit(bus_ack_o, 1'b0, "bus_ack_o after reset");
        check_byte(leds_o, 8'h00, "leds_o after reset");
        check_bit(timer_irq_o, 1'b0, "timer_irq_o after reset");
        bus_read({PAGE_PRNG, PRNG_SEED_LO}, got);
        check_byte(got, 8'h01, "prng state low after reset");
        bus_read({PAGE_PRNG, PRNG_SEED_HI}, got);
        check_byte(got, 8'h00, "prng state high after reset");
        lfsr_model = 16'h0001;
    endtask

    task automatic test_ram();
        logic [31:0] addrs [$];
        logic [31:0] addr;
        wb_data_t    data;
        wb_data_t    got;
        for (int i = 0; i < RAM_ACCESSES; i++) begin
            addr = ram_address();
            data = 8'($urandom);
            bus_write(addr, data);
            ram_model[addr % `SOC_RAM_DEPTH] = data;
            addrs.push_back(addr);
        end
        foreach (addrs[i]) begin
            bus_read(addrs[i], got);
            check_byte(got, ram_model[addrs[i] % `SOC_RAM_DEPTH], "ram read back");
        end
        // same byte seen one depth higher
        addr = $urandom & 32'h00FF_FFFF;
        data = 8'($urandom);
        bus_write(addr, data);
        ram_model[addr % `SOC_RAM_DEPTH] = data;
        bus_read(addr + `SOC_RAM_DEPTH, got);
        check_byte(got, data, "ram alias read");
    endtask

    task automatic test_leds();
        wb_data_t data;
        wb_data_t offset;
        wb_data_t got;
        data   = 8'($urandom);
        offset = 8'($urandom);
        bus_write({PAGE_LEDS, offset}, data);
        check_byte(leds_o, data, "leds_o after write");
        bus_read({PAGE_LEDS, 8'h00}, got);
        check_byte(got, data, "led register read back");
    endtask

    task automatic test_prng();
        logic [15:0] seed;
        wb_data_t    got;
        seed = 16'($urandom);
        bus_write({PAGE_PRNG, PRNG_SEED_LO}, seed[7:0]);
        lfsr_model = seed_load(lfsr_model, seed[7:0], 1'b0);
        bus_write({PAGE_PRNG, PRNG_SEED_HI}, seed[15:8]);
        lfsr_model = seed_load(lfsr_model, seed[15:8], 1'b1);
        for (int i = 0; i < PRNG_READS; i++) begin
            bus_read({PAGE_PRNG, PRNG_OUT}, got);
            check_byte(got, lfsr_model[7:0], "prng output");
            lfsr_model = lfsr_next(lfsr_model);
        end
        // zero seed must come back as 0x0001
        bus_write({PAGE_PRNG, PRNG_SEED_LO}, 8'h00);
        bus_write({PAGE_PRNG, PRNG_SEED_HI}, 8'h00);
        bus_read({PAGE_PRNG, PRNG_SEED_LO}, got);
        check_byte(got, 8'h01, "prng state low after zero seed");
        bus_read({PAGE_PRNG, PRNG_SEED_HI}, got);
        check_byte(got, 8'h00, "prng state high after zero seed");
    endtask

    task automatic test_timer();
        wb_data_t    ctrl;
        wb_data_t    status;
        int unsigned polls;
        bus_write({PAGE_TIMER, TIMER_CMP_LO}, 8'd20);
        bus_write({PAGE_TIMER, TIMER_CMP_HI}, 8'd0);
        ctrl = '0;
        ctrl[TIMER_CTRL_EN]     = 1'b1;
        ctrl[TIMER_CTRL_IRQ_EN] = 1'b1;
        bus_write({PAGE_TIMER, TIMER_CTRL}, ctrl);
        polls  = 0;
        status = '0;
        while (status[TIMER_STAT_PEND] !== 1'b1 && polls < POLL_MAX) begin
            bus_read({PAGE_TIMER, TIMER_STATUS}, status);
            polls++;
        end
        if (status[TIMER_STAT_PEND] !== 1'b1) begin
            value_errors++;
            $display("timer pending flag never rose within %0d status reads", polls);
        end
        check_bit(timer_irq_o, 1'b1, "timer_irq_o with pending and irq enable");
        ctrl[TIMER_CTRL_IRQ_EN] = 1'b0;
        bus_write({PAGE_TIMER, TIMER_CTRL}, ctrl);
        check_bit(timer_irq_o, 1'b0, "timer_irq_o with irq enable cleared");
        bus_read({PAGE_TIMER, TIMER_STATUS}, status);
        check_bit(status[TIMER_STAT_PEND], 1'b1, "pending with irq enable cleared");
        // stop the count so no new match races the clear
        ctrl = '0;
        ctrl[TIMER_CTRL_IRQ_EN] = 1'b1;
        bus_write({PAGE_TIMER, TIMER_CTRL}, ctrl);
        check_bit(timer_irq_o, 1'b1, "timer_irq_o with timer stopped");
        status = '0;
        status[TIMER_STAT_PEND] = 1'b1;
        bus_write({PAGE_TIMER, TIMER_STATUS}, status);
        bus_read({PAGE_TIMER, TIMER_STATUS}, status);
        check_bit(status[TIMER_STAT_PEND], 1'b0, "pending after clear");
        check_bit(timer_irq_o, 1'b0, "timer_irq_o after clear");
    endtask

    initial begin
        arst_n_i     = 1'b0;
        bus_stb_i    = 1'b0;
        bus_we_i     = 1'b0;
        bus_adr_i    = '0;
        bus_dat_i    = '0;
        value_errors = 0;
        ack_errors   = 0;
        void'($urandom(32'he167));
        repeat (10) @(negedge clk);
        arst_n_i = 1'b1;
        @(negedge clk);
        test_reset();
        test_ram();
        test_leds();
        test_prng();
        test_timer();
        @(negedge clk);
        $display("value errors: %0d, acknowledge errors: %0d", value_errors, ack_errors);
        if (value_errors == 0 && ack_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: wb8_soc_top.f
+incdir+hw
hw/soc_bus_pkg.sv
hw/soc_periph_pkg.sv
hw/wb8_if.sv
hw/wb8_decoder.sv
hw/ram_wb8.sv
hw/timer_wb8.sv
hw/prng_wb8.sv
hw/leds_wb8.sv
hw/wb8_soc_top.sv
test/wb8_soc_tb.sv

// File: Bender.yml
package:
  name: wb8_soc

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/soc_bus_pkg.sv
      - hw/soc_periph_pkg.sv
      - hw/wb8_if.sv
      - hw/wb8_decoder.sv
      - hw/ram_wb8.sv
      - hw/timer_wb8.sv
      - hw/prng_wb8.sv
      - hw/leds_wb8.sv
      - hw/wb8_soc_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/wb8_soc_tb.sv
